// File: hdl/merge_pkg.sv
// shared widths and types for the 4-source merge tree; the tree depth is fixed at two levels, and SRC_W must equal that depth

package merge_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // producer payload width
    localparam int DATA_W  = 16;

    // producers feeding the tree
    localparam int NUM_SRC = 4;

    // one origin bit per tree level
    localparam int SRC_W   = 2;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    // one payload word
    typedef logic [DATA_W-1:0] data_t;

    // source index seen at the root
    // bit 1 from root node, bit 0 from first-level node
    typedef logic [SRC_W-1:0] src_t;

    // four-phase port states
    // rx walks IDLE -> WAIT_REQ_LOW
    // tx walks IDLE -> WAIT_ACK_HIGH -> WAIT_ACK_LOW
    typedef enum logic [1:0]
    {
        IDLE          = 2'd0,
        WAIT_REQ_LOW  = 2'd1,
        WAIT_ACK_HIGH = 2'd2,
        WAIT_ACK_LOW  = 2'd3
    } hs_state_t;

endpackage

// File: hdl/arbitor_last_served_2req.sv
// two requesters only; o_grant_b means nothing while o_valid is low, and the last-served bit moves only when i_en is high
`timescale 1ns/100ps

module arbitor_last_served_2req
(
    input  logic       i_clk,
    input  logic       i_rst,

    // bit 0 = req A, bit 1 = req B
    input  logic [1:0] i_req_bus,

    // grant is being consumed this cycle
    input  logic       i_en,

    // at least one request present
    output logic       o_valid,

    // 0 grants A, 1 grants B
    output logic       o_grant_b
);

    // last used register, 1 = B was served last
    logic r_last_b;

    logic w_req_a;
    logic w_req_b;

    assign w_req_a = i_req_bus[0];
    assign w_req_b = i_req_bus[1];

    // lone B wins outright
    // both present -> B only if A went last
    assign o_grant_b = (~w_req_a) | (w_req_b & ~r_last_b);
    assign o_valid   = w_req_a | w_req_b;

    // remember whoever actually got through
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_last_b <= 1'b0;
        end
        else if (i_en)
        begin
            r_last_b <= o_grant_b;
        end
    end

endmodule

// File: hdl/merge_node.sv
// TAG_IN_W of 0 means the tag inputs are ignored (tie them low); output is a single register stage, so one word in flight
`timescale 1ns/100ps

module merge_node
    import merge_pkg::*;
#(
    parameter int TAG_IN_W = 0
)
(
    input  logic                                   i_clk,
    input  logic                                   i_rst,

    // child A
    input  logic                                   i_a_valid,
    output logic                                   o_a_ready,
    input  data_t                                  i_a_data,
    input  logic [(TAG_IN_W > 0 ? TAG_IN_W-1 : 0):0] i_a_tag,

    // child B
    input  logic                                   i_b_valid,
    output logic                                   o_b_ready,
    input  data_t                                  i_b_data,
    input  logic [(TAG_IN_W > 0 ? TAG_IN_W-1 : 0):0] i_b_tag,

    // towards the parent
    output logic                                   o_valid,
    input  logic                                   i_ready,
    output data_t                                  o_data,
    output logic [TAG_IN_W:0]                      o_tag
);

    // output stage
    logic                r_valid;
    data_t               r_data;
    logic [TAG_IN_W:0]   r_tag;

    // arbiter results
    logic                w_any;
    logic                w_grant_b;

    // selected child
    data_t                                   w_sel_data;
    logic [(TAG_IN_W > 0 ? TAG_IN_W-1 : 0):0] w_sel_tag;
    logic [TAG_IN_W:0]                       w_next_tag;

    logic                w_space;
    logic                w_take;

    //////////////////////////////////////////////////////////////////////
    // arbitration
    //////////////////////////////////////////////////////////////////////

    arbitor_last_served_2req i_arb
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_req_bus ({i_b_valid, i_a_valid}),
        .i_en      (w_take),
        .o_valid   (w_any),
        .o_grant_b (w_grant_b)
    );

    // empty, or emptying on this same edge
    assign w_space = ~r_valid | i_ready;
    assign w_take  = w_space & w_any;

    // only the granted side sees ready
    assign o_a_ready = w_space & ~w_grant_b;
    assign o_b_ready = w_space & w_grant_b;

    assign w_sel_data = w_grant_b ? i_b_data : i_a_data;
    assign w_sel_tag  = w_grant_b ? i_b_tag  : i_a_tag;

    // granted side becomes the new top origin bit
    generate
        if (TAG_IN_W == 0)
        begin : g_leaf
            assign w_next_tag = w_grant_b;
        end
        else
        begin : g_inner
            assign w_next_tag = {w_grant_b, w_sel_tag[TAG_IN_W-1:0]};
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_valid <= 1'b0;
        end
        else if (w_take)
        begin
            r_valid <= 1'b1;
        end
        else if (i_ready)
        begin
            r_valid <= 1'b0;
        end
    end

    // payload, no reset
    always_ff @(posedge i_clk)
    begin
        if (w_take)
        begin
            r_data <= w_sel_data;
            r_tag  <= w_next_tag;
        end
    end

    assign o_valid = r_valid;
    assign o_data  = r_data;
    assign o_tag   = r_tag;

endmodule

// File: hdl/port_rx_4phase.sv
// producer shares i_clk so req is sampled directly; a new word waits until the buffer has drained and ack has dropped
`timescale 1ns/100ps

module port_rx_4phase
    import merge_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    // four-phase side
    input  logic  i_req,
    output logic  o_ack,
    input  data_t i_data,

    // valid/ready side
    output logic  o_valid,
    input  logic  i_ready,
    output data_t o_data
);

    hs_state_t r_state;
    logic      r_valid;
    data_t     r_data;
    logic      w_accept;

    // fresh req, buffer free
    assign w_accept = (r_state == IDLE) & i_req & ~r_valid;

    // handshake FSM
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_state <= IDLE;
        end
        else
        begin
            case (r_state)
                IDLE:         if (w_accept) r_state <= WAIT_REQ_LOW;
                WAIT_REQ_LOW: if (!i_req)   r_state <= IDLE;
                default:                    r_state <= IDLE;
            endcase
        end
    end

    // buffer fills from the producer, drains downstream
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_valid <= 1'b0;
        end
        else if (w_accept)
        begin
            r_valid <= 1'b1;
        end
        else if (i_ready)
        begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_data <= i_data;
        end
    end

    // ack held for as long as req stays up
    assign o_ack   = (r_state == WAIT_REQ_LOW);
    assign o_valid = r_valid;
    assign o_data  = r_data;

endmodule

// File: hdl/port_tx_4phase.sv
// consumer shares i_clk; o_data and o_src stay stable from req rise until ack falls, and only one word is held at a time
`timescale 1ns/100ps

module port_tx_4phase
    import merge_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    // valid/ready side
    input  logic  i_valid,
    output logic  o_ready,
    input  data_t i_data,
    input  src_t  i_src,

    // four-phase side
    output logic  o_req,
    input  logic  i_ack,
    output data_t o_data,
    output src_t  o_src
);

    hs_state_t r_state;
    data_t     r_data;
    src_t      r_src;
    logic      w_take;

    // register free only in IDLE
    assign o_ready = (r_state == IDLE);
    assign w_take  = o_ready & i_valid;

    // req up -> ack up -> req down -> ack down -> free
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_state <= IDLE;
        end
        else
        begin
            case (r_state)
                IDLE:          if (w_take) r_state <= WAIT_ACK_HIGH;
                WAIT_ACK_HIGH: if (i_ack)  r_state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW:  if (!i_ack) r_state <= IDLE;
                default:                   r_state <= IDLE;
            endcase
        end
    end

    // word and its origin
    always_ff @(posedge i_clk)
    begin
        if (w_take)
        begin
            r_data <= i_data;
            r_src  <= i_src;
        end
    end

    assign o_req  = (r_state == WAIT_ACK_HIGH);
    assign o_data = r_data;
    assign o_src  = r_src;

endmodule

// File: hdl/merge_tree_top.sv
// all producers and the consumer must run on i_clk; fixed at four sources, one buffered word per stage
`timescale 1ns/100ps

module merge_tree_top
    import merge_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst,

    // producers
    input  logic [NUM_SRC-1:0]  i_req,
    output logic [NUM_SRC-1:0]  o_ack,
    input  data_t [NUM_SRC-1:0] i_data,

    // consumer
    output logic                o_req,
    input  logic                i_ack,
    output data_t               o_data,
    output src_t                o_src
);

    //////////////////////////////////////////////////////////////////////
    // hop wires
    //////////////////////////////////////////////////////////////////////

    // rx -> first level
    logic [NUM_SRC-1:0]  rx_valid;
    logic [NUM_SRC-1:0]  rx_ready;
    data_t [NUM_SRC-1:0] rx_data;

    // first level -> root, index 0 serves sources 0/1
    logic [1:0]          l1_valid;
    logic [1:0]          l1_ready;
    data_t [1:0]         l1_data;
    logic [1:0]          l1_tag;

    // root -> tx
    logic                root_valid;
    logic                root_ready;
    data_t               root_data;
    src_t                root_tag;

    // one receive port per producer
    for (genvar n = 0; n < NUM_SRC; n++)
    begin : g_rx
        port_rx_4phase i_rx
        (
            .i_clk   (i_clk),
            .i_rst   (i_rst),
            .i_req   (i_req[n]),
            .o_ack   (o_ack[n]),
            .i_data  (i_data[n]),
            .o_valid (rx_valid[n]),
            .i_ready (rx_ready[n]),
            .o_data  (rx_data[n])
        );
    end

    // first level, pair n feeds root side n
    for (genvar p = 0; p < 2; p++)
    begin : g_l1
        merge_node #(.TAG_IN_W(0)) i_node
        (
            .i_clk     (i_clk),
            .i_rst     (i_rst),
            .i_a_valid (rx_valid[2*p]),
            .o_a_ready (rx_ready[2*p]),
            .i_a_data  (rx_data[2*p]),
            .i_a_tag   (1'b0),
            .i_b_valid (rx_valid[2*p+1]),
            .o_b_ready (rx_ready[2*p+1]),
            .i_b_data  (rx_data[2*p+1]),
            .i_b_tag   (1'b0),
            .o_valid   (l1_valid[p]),
            .i_ready   (l1_ready[p]),
            .o_data    (l1_data[p]),
            .o_tag     (l1_tag[p])
        );
    end

    // root adds bit 1 of the source index
    merge_node #(.TAG_IN_W(1)) i_node_root
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_a_valid (l1_valid[0]),
        .o_a_ready (l1_ready[0]),
        .i_a_data  (l1_data[0]),
        .i_a_tag   (l1_tag[0]),
        .i_b_valid (l1_valid[1]),
        .o_b_ready (l1_ready[1]),
        .i_b_data  (l1_data[1]),
        .i_b_tag   (l1_tag[1]),
        .o_valid   (root_valid),
        .i_ready   (root_ready),
        .o_data    (root_data),
        .o_tag     (root_tag)
    );

    port_tx_4phase i_tx
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (root_valid),
        .o_ready (root_ready),
        .i_data  (root_data),
        .i_src   (root_tag),
        .o_req   (o_req),
        .i_ack   (i_ack),
        .o_data  (o_data),
        .o_src   (o_src)
    );

endmodule

// File: sim/merge_tree_tb.sv
// sim only: run from the project root so sim/merge_tree_stim.txt is found; producers and consumer share one clock
`timescale 1ns/100ps

module merge_tree_tb
    import merge_pkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // clock, reset and DUT
    //////////////////////////////////////////////////////////////////////

    logic                clk = 1'b0;
    logic                rst;
    logic [NUM_SRC-1:0]  drv_req;
    logic [NUM_SRC-1:0]  dut_ack;
    data_t [NUM_SRC-1:0] drv_data;
    logic                dut_req;
    logic                drv_ack;
    data_t               dut_data;
    src_t                dut_src;

    // 20 ns period
    always #10 clk = ~clk;

    merge_tree_top i_merge_tree_top
    (
        .i_clk  (clk),
        .i_rst  (rst),
        .i_req  (drv_req),
        .o_ack  (dut_ack),
        .i_data (drv_data),
        .o_req  (dut_req),
        .i_ack  (drv_ack),
        .o_data (dut_data),
        .o_src  (dut_src)
    );

    // raw stimulus image
    logic [15:0] stim_mem [0:255];

    // per source expected words, head index acts as the queue pop
    data_t       exp_words [NUM_SRC][64];
    int          exp_cnt [NUM_SRC];
    int          exp_head [NUM_SRC];

    // source order seen by the consumer in this phase
    int          seq_src [0:255];
    int          seq_len = 0;

    int          err_count = 0;
    int          words_seen = 0;
    int          wd_limit = 0;
    logic        stim_ready = 1'b0;
    logic        ack_random = 1'b0;
    logic [31:0] rng_state = 32'hbd3f;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            err_count++;
            $display("[FAIL] %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // pop the head of the queue named by o_src
    task automatic score_word(input src_t s, input data_t d);
        int n;
        n = int'(s);
        words_seen++;
        if (exp_head[n] >= exp_cnt[n])
        begin
            err_count++;
            $display("ERROR at %0d ns: source %0d sent word %h but none was pending", $time, n, d);
        end
        else
        begin
            check_value($sformatf("o_data (source %0d)", n), 32'(d),
                        32'(exp_words[n][exp_head[n]]));
            exp_head[n]++;
        end
        if (seq_len < 256)
        begin
            seq_src[seq_len] = n;
        end
        seq_len++;
    endtask

    task automatic wait_ack(input int n, input logic level);
        do
        begin
            @(posedge clk);
            #2;
        end
        while (dut_ack[n] !== level);
    endtask

    // one producer, full four-phase cycle per word
    task automatic produce(input int n);
        int k;
        for (k = 0; k < exp_cnt[n]; k++)
        begin
            drv_data[n] = exp_words[n][k];
            drv_req[n]  = 1'b1;
            wait_ack(n, 1'b1);
            drv_req[n]  = 1'b0;
            wait_ack(n, 1'b0);
        end
    endtask

    // one node, both children backlogged, so each output flips the source
    task automatic check_pair_alternation();
        int k;
        check_value("o_src[1] of first word", 32'(seq_src[0] / 2), 32'd0);
        for (k = 1; k < seq_len; k++)
        begin
            check_value($sformatf("o_src at output %0d", k), seq_src[k], seq_src[k-1] ^ 1);
        end
    endtask

    // every 8 outputs hold each source twice until one runs dry
    task automatic check_window_balance();
        int hits [NUM_SRC];
        int last_pos [NUM_SRC];
        int limit;
        int s;
        int k;
        int n;
        for (n = 0; n < NUM_SRC; n++)
            last_pos[n] = -1;
        for (k = 0; k < seq_len; k++)
            last_pos[seq_src[k]] = k;
        limit = seq_len - 1;
        for (n = 0; n < NUM_SRC; n++)
        begin
            if (last_pos[n] < limit)
                limit = last_pos[n];
        end
        for (s = 0; s + 7 <= limit; s++)
        begin
            for (n = 0; n < NUM_SRC; n++)
                hits[n] = 0;
            for (k = s; k < s + 8; k++)
                hits[seq_src[k]]++;
            for (n = 0; n < NUM_SRC; n++)
            begin
                check_value($sformatf("o_src %0d count in outputs %0d..%0d", n, s, s + 7),
                            hits[n], 2);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // consumer model
    //////////////////////////////////////////////////////////////////////

    initial
    begin : consumer
        int unsigned ack_delay;

        drv_ack = 1'b0;
        forever
        begin
            @(posedge clk);
            #2;
            if (dut_req === 1'b1)
            begin
                score_word(dut_src, dut_data);
                ack_delay = 0;
                // 0 to 3 cycles of back-pressure
                if (ack_random)
                    ack_delay = xorshift32() % 32'd4;
                if (ack_delay > 0)
                begin
                    repeat (ack_delay) @(posedge clk);
                    #2;
                end
                drv_ack = 1'b1;
                do
                begin
                    @(posedge clk);
                    #2;
                end
                while (dut_req === 1'b1);
                drv_ack = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin : main
        int ptr;
        int n;
        int k;
        int total;
        int phase_words;
        int active;

        rst      = 1'b1;
        drv_req  = '0;
        drv_data = '0;
        for (n = 0; n < NUM_SRC; n++)
        begin
            exp_cnt[n]  = 0;
            exp_head[n] = 0;
        end
        $readmemh("sim/merge_tree_stim.txt", stim_mem);

        // word total sets the watchdog budget
        ptr   = 0;
        total = 0;
        while (stim_mem[ptr] != 16'h0000)
        begin
            phase_words = 0;
            for (n = 0; n < NUM_SRC; n++)
                phase_words += int'(stim_mem[ptr+2+n]);
            total += phase_words;
            ptr   += 6 + phase_words;
        end
        if (total == 0)
        begin
            err_count++;
            $display("ERROR: no stimulus words were read from sim/merge_tree_stim.txt");
        end
        wd_limit   = 64 * total + 200;
        stim_ready = 1'b1;

        // reset held over 3 edges, outputs must stay quiet
        for (k = 0; k < 3; k++)
        begin
            @(posedge clk);
            #2;
            check_value("o_ack", 32'(dut_ack), 32'd0);
            check_value("o_req", 32'(dut_req), 32'd0);
        end
        rst = 1'b0;
        for (k = 0; k < 2; k++)
        begin
            @(posedge clk);
            #2;
            check_value("o_ack", 32'(dut_ack), 32'd0);
            check_value("o_req", 32'(dut_req), 32'd0);
        end

        ptr = 0;
        while (stim_mem[ptr] != 16'h0000)
        begin
            ack_random  = stim_mem[ptr+1][0];
            phase_words = 0;
            active      = 0;
            for (n = 0; n < NUM_SRC; n++)
            begin
                exp_cnt[n]  = int'(stim_mem[ptr+2+n]);
                exp_head[n] = 0;
                phase_words += exp_cnt[n];
                if (exp_cnt[n] > 0)
                    active++;
            end
            $display("phase %0d: %0d words, random acks %0b", stim_mem[ptr], phase_words,
                     ack_random);
            ptr += 6;
            for (n = 0; n < NUM_SRC; n++)
            begin
                for (k = 0; k < exp_cnt[n]; k++)
                begin
                    exp_words[n][k] = stim_mem[ptr];
                    ptr++;
                end
            end
            seq_len = 0;
            fork
                produce(0);
                produce(1);
                produce(2);
                produce(3);
            join
            // all producers done, wait for the tail of the tree
            wait (seq_len >= phase_words);
            @(posedge clk);
            #2;
            for (n = 0; n < NUM_SRC; n++)
            begin
                check_value($sformatf("words left for source %0d", n),
                            exp_cnt[n] - exp_head[n], 0);
            end
            if (!ack_random && active == 2)
                check_pair_alternation();
            if (!ack_random && active == NUM_SRC)
                check_window_balance();
        end

        $display("checks done: %0d errors, %0d words received", err_count, words_seen);
        if (err_count == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial
    begin : watchdog
        wait (stim_ready);
        repeat (wd_limit) @(posedge clk);
        err_count++;
        $display("ERROR: run timed out after %0d cycles, a word or handshake never completed",
                 wd_limit);
        $display("checks done: %0d errors, %0d words received", err_count, words_seen);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: sim/merge_tree_stim.txt
// merge tree stimulus in hex: phase, ack mode (0 immediate, 1 random), word counts of sources 0 to 3
// each header is followed by the words of source 0, 1, 2 and 3 in turn; phase 0000 ends the list
// phases 1 to 4: one source at a time
0001 0000 0003 0000 0000 0000
1a01 1a02 1a03
0002 0000 0000 0003 0000 0000
2b01 2b02 2b03
0003 0000 0000 0000 0003 0000
3c01 3c02 3c03
0004 0000 0000 0000 0000 0003
4d01 4d02 4d03
// phase 5: sources 0 and 1 contend
0005 0000 0006 0006 0000 0000
5000 5001 5002 5003 5004 5005
5100 5101 5102 5103 5104 5105
// phase 6: full load, immediate acks
0006 0000 0008 0008 0008 0008
6000 6001 6002 6003 6004 6005 6006 6007
6100 6101 6102 6103 6104 6105 6106 6107
6200 6201 6202 6203 6204 6205 6206 6207
6300 6301 6302 6303 6304 6305 6306 6307
// phase 7: full load, random ack delays
0007 0001 0008 0008 0008 0008
0000 ffff 8000 7fff 5555 aaaa 0001 fffe
7100 7101 7102 7103 7104 7105 7106 7107
7200 7201 7202 7203 7204 7205 7206 7207
7300 7301 7302 7303 7304 7305 7306 7307
0000

// File: sources.f
hdl/merge_pkg.sv
hdl/arbitor_last_served_2req.sv
hdl/merge_node.sv
hdl/port_rx_4phase.sv
hdl/port_tx_4phase.sv
hdl/merge_tree_top.sv
sim/merge_tree_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the merge tree testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps -f sources.f \
    --top-module merge_tree_tb -o merge_tree_sim
./obj_dir/merge_tree_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: testbench reported a pass"
else
    echo "run_sim: testbench reported a failure"
    exit 1
fi
